// ==== list.f ====
verilog/vic_link_pkg.sv
verilog/apb_if.sv
verilog/serial_rx.sv
verilog/cmd_bridge.sv
verilog/raster_timing.sv
verilog/serial_tx.sv
verilog/vic_link_top.sv
sim/tb_vic_link.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vic_link -f list.f -o tb_vic_link || exit 1
out=$(./obj_dir/tb_vic_link)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1

// ==== sim/tb_vic_link.sv ====
`timescale 1ns/1ps

module tb_vic_link import vic_link_pkg::*; ();

    localparam int CLKS_PER_BIT = 16;
    localparam int RX_TIMEOUT   = 4000;   // cycles for the longest frame plus its reply
    localparam int HS_TIMEOUT   = 400;

    logic             sys_clock;
    logic             rst_n;
    logic             rx;
    logic             tx;
    logic             hsync;
    logic             vsync;
    logic             active;
    logic [REG_W-1:0] raster;

    logic [REG_W-1:0] reg_model [0:7];    // entry 7 is raster which reads 0 while disabled
    logic [REG_W-1:0] reply;              // last byte seen on tx
    logic [REG_W-1:0] reply_raster;       // raster in the cycle prdata was taken
    integer           seed;
    int               errors;
    int               test_errs;
    int               tests_run;
    int               tests_ok;
    int               vs_lines;

    vic_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) UUT (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active),
        .raster    (raster)
    );

    initial begin
        sys_clock = 1'b0;
        forever #20 sys_clock = ~sys_clock;   // 40 ns period
    end

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp)
        else begin
            $display("[FAIL] t=%0d ns: %s expected 0x%02h, got 0x%02h", $time, what, exp, got);
            errors++;
        end
    endtask

    task automatic check_int(input string what, input int exp, input int got);
        assert (got == exp)
        else begin
            $display("[FAIL] t=%0d ns: %s expected %0d, got %0d", $time, what, exp, got);
            errors++;
        end
    endtask

    // host side 8n1 out that starts and ends at posedge + 2 ns
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};               // stop, data, start
        repeat (10) begin
            rx    = frame[0];
            frame = frame >> 1;
            repeat (CLKS_PER_BIT) @(posedge sys_clock);
            #2;
        end
    endtask

    // host side 8n1 in sampled at negedge near mid bit
    task automatic recv_byte();
        int         n;
        logic [7:0] h1;
        logic [7:0] h2;
        n  = 0;
        h1 = raster;
        h2 = raster;
        @(negedge sys_clock);
        while (tx !== 1'b0 && n < RX_TIMEOUT) begin
            h2 = h1;                           // raster two cycles back
            h1 = raster;
            @(negedge sys_clock);
            n++;
        end
        if (n >= RX_TIMEOUT) begin
            $display("timeout: no reply start bit on tx within %0d cycles", n);
            errors++;
        end else begin
            reply_raster = h2;                 // access cycle sits 2 cycles before tx falls
            repeat (CLKS_PER_BIT / 2) @(negedge sys_clock);
            check_int("tx start bit", 0, int'(tx));
            repeat (8) begin
                repeat (CLKS_PER_BIT) @(negedge sys_clock);
                reply = {tx, reply[7:1]};      // lsb first
            end
            repeat (CLKS_PER_BIT) @(negedge sys_clock);
            check_int("tx stop bit", 1, int'(tx));
        end
    endtask

    // send a frame of 1 to 3 bytes while listening for the reply
    task automatic run_frame(input logic [7:0] b0, input logic [7:0] b1,
                             input logic [7:0] b2, input int nbytes);
        fork
            begin
                send_byte(b0);
                if (nbytes > 1)
                    send_byte(b1);
                if (nbytes > 2)
                    send_byte(b2);
            end
            recv_byte();
        join
        @(posedge sys_clock);
        #2;                                    // back on the drive point
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data,
                             input logic [7:0] exp);
        run_frame(OP_WRITE, addr, data, 3);
        check_byte($sformatf("tx reply to W %0d", addr), exp, reply);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [7:0] exp);
        run_frame(OP_READ, addr, 8'h00, 2);
        check_byte($sformatf("tx reply to R %0d", addr), exp, reply);
    endtask

    task automatic set_reg(input logic [2:0] ra, input logic [7:0] data);
        write_reg({5'd0, ra}, data, REPLY_ACK);
        reg_model[ra] = data;
    endtask

    // per line checks from hsync rise against the model registers
    task automatic check_lines(input int nlines);
        int         n;
        int         hs;
        int         act;
        int         period;
        logic       prev;
        logic       last_hs;
        logic [7:0] line;
        n      = 0;
        period = int'(reg_model[0]) + 1;
        @(negedge sys_clock);
        prev = hsync;
        @(negedge sys_clock);
        while (!(hsync && !prev) && n < HS_TIMEOUT) begin
            prev = hsync;
            @(negedge sys_clock);
            n++;
        end
        if (n >= HS_TIMEOUT) begin
            $display("timeout: hsync never rose within %0d cycles", n);
            errors++;
        end else begin
            for (int l = 0; l < nlines; l++) begin
                line    = raster;              // same line for the next period samples
                hs      = 0;
                act     = 0;
                last_hs = 1'b0;
                check_int("vsync", (line <= reg_model[4]) ? 1 : 0, int'(vsync));
                if (vsync)
                    vs_lines++;
                repeat (period) begin
                    hs     += int'(hsync);
                    act    += int'(active);
                    last_hs = hsync;
                    @(negedge sys_clock);
                end
                check_int("hsync high cycles", int'(reg_model[1]) + 1, hs);
                check_int("active cycles", (line <= reg_model[5]) ?
                          int'(reg_model[2]) + 1 : 0, act);
                check_int("hsync at end of line", 0, int'(last_hs));
                check_int("hsync after one period", 1, int'(hsync));
            end
        end
        @(posedge sys_clock);
        #2;
    endtask

    task automatic test_done(input string name);
        tests_run++;
        if (errors == test_errs) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    initial begin
        logic [2:0] ra;
        logic [7:0] data;
        logic [7:0] bad;
        seed      = 32'h9e63e4e1;
        errors    = 0;
        test_errs = 0;
        tests_run = 0;
        tests_ok  = 0;
        vs_lines  = 0;
        reply     = 8'h00;
        rst_n     = 1'b0;
        rx        = 1'b1;                      // serial idle
        reg_model[0] = 8'd63;
        reg_model[1] = 8'd7;
        reg_model[2] = 8'd47;
        reg_model[3] = 8'd31;
        reg_model[4] = 8'd1;
        reg_model[5] = 8'd23;
        reg_model[6] = 8'd0;
        reg_model[7] = 8'd0;
        repeat (3) @(posedge sys_clock);
        #2;
        rst_n = 1'b1;
        repeat (4) @(posedge sys_clock);
        #2;

        // reset values and idle outputs
        check_int("tx", 1, int'(tx));
        check_int("hsync", 0, int'(hsync));
        check_int("vsync", 0, int'(vsync));
        check_int("active", 0, int'(active));
        for (int i = 0; i < 8; i++)
            read_reg(8'(i), reg_model[3'(i)]);
        test_done("reset readback");

        repeat (20) begin
            ra   = 3'($unsigned($random(seed)) % 6);
            data = 8'($random(seed));
            set_reg(ra, data);
        end
        for (int i = 0; i < 7; i++)
            read_reg(8'(i), reg_model[3'(i)]);
        test_done("random writes and reads");

        bad = 8'($unsigned($random(seed)) % 248 + 8);   // 8 .. 255
        write_reg(bad, 8'($random(seed)), REPLY_NAK);
        read_reg(bad, REPLY_NAK);
        write_reg(REG_RASTER, 8'h05, REPLY_NAK);
        data = 8'($random(seed));
        while (data == OP_WRITE || data == OP_READ)
            data = 8'($random(seed));
        run_frame(data, 8'h00, 8'h00, 1);     // lone bad opcode
        check_byte("tx reply to bad opcode", REPLY_NAK, reply);
        ra = 3'($unsigned($random(seed)) % 7);
        read_reg({5'd0, ra}, reg_model[ra]);
        test_done("error replies");

        // 20 cycle lines and 10 line frames
        set_reg(3'd0, 8'd19);
        set_reg(3'd1, 8'd3);
        set_reg(3'd2, 8'd15);
        set_reg(3'd3, 8'd9);
        set_reg(3'd4, 8'd1);
        set_reg(3'd5, 8'd7);
        set_reg(3'd6, 8'd1);
        check_lines(12);
        test_done("horizontal timing");

        vs_lines = 0;
        check_lines(10);                       // exactly one frame
        check_int("vsync lines per frame", int'(reg_model[4]) + 1, vs_lines);
        run_frame(OP_READ, REG_RASTER, 8'h00, 2);
        check_int("raster read in range", 1, (reply <= reg_model[3]) ? 1 : 0);
        check_byte("raster read vs raster port", reply_raster, reply);
        test_done("vertical timing and raster");

        set_reg(3'd6, 8'd0);
        check_int("hsync", 0, int'(hsync));
        check_int("vsync", 0, int'(vsync));
        check_int("active", 0, int'(active));
        check_byte("raster", 8'd0, raster);
        read_reg(REG_RASTER, 8'd0);
        test_done("disable");

        $display("summary: %0d of %0d tests ok, %0d check errors", tests_ok, tests_run, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== verilog/apb_if.sv ====
`timescale 1ns/1ps

// apb between command bridge and raster timing, no pprot/pstrb
interface apb_if import vic_link_pkg::*; ();

    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [REG_W-1:0] paddr;
    logic [REG_W-1:0] pwdata;
    logic [REG_W-1:0] prdata;
    logic             pready;
    logic             pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// ==== verilog/cmd_bridge.sv ====
`timescale 1ns/1ps

module cmd_bridge import vic_link_pkg::*; (
    input  logic             sys_clock,
    input  logic             rst_n,
    input  logic [REG_W-1:0] rx_data,
    input  logic             rx_valid,
    apb_if.master            apb,
    output logic [REG_W-1:0] tx_data,
    output logic             tx_valid,
    input  logic             tx_busy
);

    typedef enum logic [2:0] {
        ST_IDLE,    // waiting for opcode
        ST_ADDR,    // waiting for address byte
        ST_DATA,    // waiting for write data
        ST_SETUP,   // apb setup phase
        ST_ACCESS,  // apb access phase
        ST_REPLY    // hand reply byte to tx
    } state_e;

    state_e           state;
    link_op_e         op;
    logic             is_write;
    logic [REG_W-1:0] addr_q;
    logic [REG_W-1:0] wdata_q;
    logic [REG_W-1:0] reply_q;

    assign op = link_op_e'(rx_data);

    // apb strobes straight from state with addr and data held in regs
    assign apb.psel    = (state == ST_SETUP) || (state == ST_ACCESS);
    assign apb.penable = (state == ST_ACCESS);
    assign apb.pwrite  = is_write;
    assign apb.paddr   = addr_q;
    assign apb.pwdata  = wdata_q;

    assign tx_data  = reply_q;
    assign tx_valid = (state == ST_REPLY) && !tx_busy;  // waits out a busy tx

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            is_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_valid) begin
                        case (op)
                            OP_WRITE: begin
                                is_write <= 1'b1;
                                state    <= ST_ADDR;
                            end
                            OP_READ: begin
                                is_write <= 1'b0;
                                state    <= ST_ADDR;
                            end
                            default: state <= ST_REPLY;  // nak right away
                        endcase
                    end
                end
                ST_ADDR:
                    if (rx_valid)
                        state <= is_write ? ST_DATA : ST_SETUP;
                ST_DATA:
                    if (rx_valid)
                        state <= ST_SETUP;
                ST_SETUP:  state <= ST_ACCESS;
                ST_ACCESS:
                    if (apb.pready)
                        state <= ST_REPLY;
                ST_REPLY:
                    if (tx_valid)
                        state <= ST_IDLE;   // byte taken by tx
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame payload and reply byte
    always_ff @(posedge sys_clock) begin
        if (state == ST_IDLE && rx_valid && op != OP_WRITE && op != OP_READ)
            reply_q <= REPLY_NAK;
        if (state == ST_ADDR && rx_valid)
            addr_q <= rx_data;
        if (state == ST_DATA && rx_valid)
            wdata_q <= rx_data;
        if (state == ST_ACCESS && apb.pready) begin
            if (apb.pslverr)
                reply_q <= REPLY_NAK;
            else
                reply_q <= is_write ? REPLY_ACK : apb.prdata;
        end
    end

    // access phase follows setup and keeps addr, data and pwrite stable
    a_apb_penable: assert property (@(posedge sys_clock) disable iff (!rst_n)
        apb.penable |-> apb.psel && $past(apb.psel) && $stable(apb.paddr) &&
                        $stable(apb.pwdata) && $stable(apb.pwrite))
        else $error("penable without setup phase or apb address/data not held");

    // tx takes the offered byte at once and goes busy
    a_tx_no_busy: assert property (@(posedge sys_clock) disable iff (!rst_n)
        tx_valid |=> $past(!tx_busy) && tx_busy)
        else $error("tx_valid while tx_busy or byte not taken by tx");

endmodule

// ==== verilog/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing import vic_link_pkg::*; (
    input  logic             sys_clock,
    input  logic             rst_n,
    apb_if.slave             apb,
    output logic             hsync,
    output logic             vsync,
    output logic             active,
    output logic [REG_W-1:0] raster
);

    logic [REG_W-1:0] h_total, h_sync_end, h_active_end;
    logic [REG_W-1:0] v_total, v_sync_end, v_active_end;
    logic             enable;
    logic [REG_W-1:0] h_cnt, v_cnt;
    reg_addr_e        addr;
    logic             wr_en;

    assign addr = reg_addr_e'(apb.paddr);

    // zero wait states
    assign apb.pready  = 1'b1;
    assign apb.pslverr = apb.psel &&
                         ((apb.paddr > REG_LAST) || (apb.pwrite && addr == REG_RASTER));
    assign wr_en       = apb.psel && apb.penable && apb.pwrite && !apb.pslverr;

    always_comb begin
        case (addr)
            REG_H_TOTAL:      apb.prdata = h_total;
            REG_H_SYNC_END:   apb.prdata = h_sync_end;
            REG_H_ACTIVE_END: apb.prdata = h_active_end;
            REG_V_TOTAL:      apb.prdata = v_total;
            REG_V_SYNC_END:   apb.prdata = v_sync_end;
            REG_V_ACTIVE_END: apb.prdata = v_active_end;
            REG_CTRL:         apb.prdata = {{(REG_W-1){1'b0}}, enable};
            REG_RASTER:       apb.prdata = v_cnt;   // live line
            default:          apb.prdata = '0;
        endcase
    end

    // register file, defaults give a 64x32 raster
    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            h_total      <= 8'd63;
            h_sync_end   <= 8'd7;
            h_active_end <= 8'd47;
            v_total      <= 8'd31;
            v_sync_end   <= 8'd1;
            v_active_end <= 8'd23;
            enable       <= 1'b0;
        end else if (wr_en) begin
            case (addr)
                REG_H_TOTAL:      h_total      <= apb.pwdata;
                REG_H_SYNC_END:   h_sync_end   <= apb.pwdata;
                REG_H_ACTIVE_END: h_active_end <= apb.pwdata;
                REG_V_TOTAL:      v_total      <= apb.pwdata;
                REG_V_SYNC_END:   v_sync_end   <= apb.pwdata;
                REG_V_ACTIVE_END: v_active_end <= apb.pwdata;
                REG_CTRL:         enable       <= apb.pwdata[0];
                default:          enable       <= enable;  // raster is read only
            endcase
        end
    end

    // h/v counters, >= so a shrunk total wraps at once
    always_ff @(posedge sys_clock) begin
        if (!rst_n || !enable) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt >= h_total) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt >= v_total) ? '0 : v_cnt + 1'b1;  // next line
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // one cycle behind the counters
    always_ff @(posedge sys_clock) begin
        if (!rst_n || !enable) begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end else begin
            hsync  <= (h_cnt <= h_sync_end);
            vsync  <= (v_cnt <= v_sync_end);
            active <= (h_cnt <= h_active_end) && (v_cnt <= v_active_end);
        end
    end

    assign raster = v_cnt;

    // once inside the line the count stays there unless h_total is rewritten
    a_h_in_range: assert property (@(posedge sys_clock) disable iff (!rst_n)
        enable && (h_cnt <= h_total) |=> !enable || $changed(h_total) || (h_cnt <= h_total))
        else $error("h_cnt beyond h_total");

endmodule

// ==== verilog/serial_rx.sv ====
`timescale 1ns/1ps

module serial_rx import vic_link_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic             sys_clock,
    input  logic             rst_n,
    input  logic             rx,
    output logic [REG_W-1:0] rx_data,
    output logic             rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_MAX  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_MAX = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic             rx_meta, rx_s, rx_d;  // two flop sync plus edge history
    logic [CNT_W-1:0] cnt;                  // cycles within the current bit
    logic [2:0]       bit_idx;
    logic [REG_W-1:0] shreg;
    logic             tick;
    logic             data_sample, stop_sample;

    assign tick        = (cnt == BIT_MAX);
    assign data_sample = (state == RX_DATA) && tick;   // middle of a data bit
    assign stop_sample = (state == RX_STOP) && tick;   // middle of stop bit

    // line idles high
    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_d    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            rx_d    <= rx_s;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;               // single cycle pulse
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_d && !rx_s)       // falling edge, start bit
                        state <= RX_START;
                end
                RX_START: begin
                    if (cnt == HALF_MAX) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;  // glitch, back off
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        cnt      <= '0;
                        rx_valid <= rx_s;    // low stop bit drops the frame
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge sys_clock) begin
        if (data_sample)
            shreg <= {rx_s, shreg[REG_W-1:1]};
        if (stop_sample && rx_s)
            rx_data <= shreg;
    end

endmodule

// ==== verilog/serial_tx.sv ====
`timescale 1ns/1ps

module serial_tx import vic_link_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic             sys_clock,
    input  logic             rst_n,
    input  logic [REG_W-1:0] tx_data,
    input  logic             tx_valid,
    output logic             tx_busy,
    output logic             tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_MAX = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] cnt;       // cycles in current bit
    logic [3:0]       bit_idx;   // 0 start .. 9 stop
    logic [9:0]       shreg;     // stop, data, start with lsb out first

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            shreg   <= '1;           // line idle high
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (tx_valid) begin
                shreg   <= {1'b1, tx_data, 1'b0};
                tx_busy <= 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (cnt == BIT_MAX) begin
                cnt     <= '0;
                shreg   <= {1'b1, shreg[9:1]};  // back fill with idle level
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd9)
                    tx_busy <= 1'b0;            // stop bit done
            end
        end
    end

    assign tx = shreg[0];

endmodule

// ==== verilog/vic_link_pkg.sv ====
package vic_link_pkg;

    // width of every register, data word and address on the link
    localparam int REG_W = 8;

    // first byte of a host frame, plain ascii
    typedef enum logic [REG_W-1:0] {
        OP_WRITE = 8'h57,   // 'W' then addr, data
        OP_READ  = 8'h52    // 'R' then addr
    } link_op_e;

    // register map of the raster timing block
    typedef enum logic [REG_W-1:0] {
        REG_H_TOTAL      = 8'd0,   // cycles per line minus one
        REG_H_SYNC_END   = 8'd1,   // last hsync cycle
        REG_H_ACTIVE_END = 8'd2,   // last active cycle of a line
        REG_V_TOTAL      = 8'd3,   // lines per frame minus one
        REG_V_SYNC_END   = 8'd4,   // last vsync line
        REG_V_ACTIVE_END = 8'd5,   // last active line
        REG_CTRL         = 8'd6,   // bit 0 enable
        REG_RASTER       = 8'd7    // live line, read only
    } reg_addr_e;

    // highest decoded address, anything above gets pslverr
    localparam logic [REG_W-1:0] REG_LAST = 8'd7;

    // reply bytes back to the host
    localparam logic [REG_W-1:0] REPLY_ACK = 8'h06;
    localparam logic [REG_W-1:0] REPLY_NAK = 8'h15;

endpackage

// ==== verilog/vic_link_top.sv ====
`timescale 1ns/1ps

module vic_link_top import vic_link_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic             sys_clock,
    input  logic             rst_n,
    input  logic             rx,        // host serial in, idle high
    output logic             tx,        // reply serial out, idle high
    output logic             hsync,
    output logic             vsync,
    output logic             active,
    output logic [REG_W-1:0] raster     // current line
);

    logic [REG_W-1:0] rx_data;
    logic             rx_valid;
    logic [REG_W-1:0] tx_data;
    logic             tx_valid;
    logic             tx_busy;

    apb_if apb ();

    serial_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    cmd_bridge u_bridge (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .apb       (apb.master),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_busy   (tx_busy)
    );

    raster_timing u_timing (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .apb       (apb.slave),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active),
        .raster    (raster)
    );

    serial_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_busy   (tx_busy),
        .tx        (tx)
    );

endmodule
